// File: rtl/divsqrt_pkg.sv
// ------------------------------------------------------------
// Shared types and constants of the integer divide/sqrt unit
// Formats, operations, status flags and width helpers
// ------------------------------------------------------------
package divsqrt_pkg;

  localparam int unsigned MAX_WIDTH = 64; // Datapath width
  localparam int unsigned TAG_WIDTH = 4;  // Default tag width

  // Destination format as seen at the unit boundary
  typedef enum logic [1:0] {
    FMT64     = 2'd0,
    FMT32     = 2'd1,
    FMT16     = 2'd2,
    FMT_UNSUP = 2'd3  // Not supported, flagged as nv
  } fmt_e;

  // One-hot format used inside the unit, all zero when unsupported
  typedef logic [2:0] fmt_onehot_t;

  localparam fmt_onehot_t FMT_OH64 = 3'b100;
  localparam fmt_onehot_t FMT_OH32 = 3'b010;
  localparam fmt_onehot_t FMT_OH16 = 3'b001;

  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } op_e;

  typedef struct packed {
    logic nv; // Unsupported format
    logic dz; // Divide by zero
  } status_t;

  // Bit width of a one-hot format, full width when unsupported
  function automatic int unsigned fmt_width(fmt_onehot_t fmt);
    unique case (fmt)
      FMT_OH32: return 32;
      FMT_OH16: return 16;
      default:  return MAX_WIDTH;
    endcase
  endfunction

endpackage

// File: rtl/divsqrt_pipe_stage.sv
// ------------------------------------------------------------
// Elastic valid/ready pipeline with flush, generic payload
// ------------------------------------------------------------
`timescale 1ns/1ps

module divsqrt_pipe_stage #(
  parameter type         PayloadType = logic,
  parameter int unsigned NumRegs     = 0
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,
  // Upstream side
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  PayloadType in_data_i,
  // Downstream side
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output PayloadType out_data_o,
  output logic       valid_any_o  // Some stage holds data
);

  // Index i holds the signal after i register stages
  logic       [0:NumRegs] valid;
  logic       [0:NumRegs] ready;  // Combinational all the way back
  PayloadType             data [0:NumRegs];

  assign valid[0]   = in_valid_i;
  assign data[0]    = in_data_i;
  assign in_ready_o = ready[0];

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic reg_en;
    // Advance when next stage takes our item or holds only a bubble
    assign ready[i] = ready[i+1] | ~valid[i+1];
    assign reg_en   = ready[i] & valid[i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid[i+1] <= 1'b0;           // Drop everything in flight
      end else if (ready[i]) begin
        valid[i+1] <= valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_en) data[i+1] <= data[i]; // Payload, only moves with valid data
    end
  end

  assign ready[NumRegs] = out_ready_i;  // Ready enters from downstream
  assign out_valid_o    = valid[NumRegs];
  assign out_data_o     = data[NumRegs];

  if (NumRegs == 0) begin : gen_no_regs
    assign valid_any_o = 1'b0;
  end else begin : gen_any
    assign valid_any_o = |valid[1:NumRegs];
  end

endmodule

// File: rtl/divsqrt_operand_box.sv
// ------------------------------------------------------------
// Issue register: one-hot format and ones-boxed operands
// ------------------------------------------------------------
`timescale 1ns/1ps

module divsqrt_operand_box (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              start_i,
  input  divsqrt_pkg::op_e                  op_i,
  input  divsqrt_pkg::fmt_e                 fmt_i,
  input  logic [divsqrt_pkg::MAX_WIDTH-1:0] operand0_i,
  input  logic [divsqrt_pkg::MAX_WIDTH-1:0] operand1_i,
  output divsqrt_pkg::op_e                  op_o,
  output divsqrt_pkg::fmt_onehot_t          fmt_onehot_o,
  output logic [divsqrt_pkg::MAX_WIDTH-1:0] src0_o,
  output logic [divsqrt_pkg::MAX_WIDTH-1:0] src1_o
);
  import divsqrt_pkg::*;

  fmt_onehot_t          fmt_onehot;
  logic [MAX_WIDTH-1:0] box_mask;   // Ones above the format width
  logic [MAX_WIDTH-1:0] src0, src1;

  // Format translation
  always_comb begin
    unique case (fmt_i)
      FMT64:   fmt_onehot = FMT_OH64;
      FMT32:   fmt_onehot = FMT_OH32;
      FMT16:   fmt_onehot = FMT_OH16;
      default: fmt_onehot = '0;       // Unsupported
    endcase
  end

  assign box_mask = ~({MAX_WIDTH{1'b1}} >> (MAX_WIDTH - fmt_width(fmt_onehot)));
  assign src0     = (fmt_onehot == '0) ? '1 : (operand0_i | box_mask);
  assign src1     = (fmt_onehot == '0) ? '1 : (operand1_i | box_mask);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_o         <= OP_DIV;
      fmt_onehot_o <= '0;
    end else if (start_i) begin
      op_o         <= op_i;
      fmt_onehot_o <= fmt_onehot;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      src0_o <= src0;
      src1_o <= src1;
    end
  end

endmodule

// File: rtl/divsqrt_iter_core.sv
// ------------------------------------------------------------
// Iterative restoring divider and bit-pair square root
// One result bit per cycle, result rules and boxing at the end
// ------------------------------------------------------------
`timescale 1ns/1ps

module divsqrt_iter_core (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              flush_i,
  input  logic                              start_i,
  input  divsqrt_pkg::op_e                  op_i,
  input  divsqrt_pkg::fmt_onehot_t          fmt_onehot_i,
  input  logic [divsqrt_pkg::MAX_WIDTH-1:0] src0_i,
  input  logic [divsqrt_pkg::MAX_WIDTH-1:0] src1_i,
  output logic                              done_o,
  output logic                              busy_o,
  output logic [divsqrt_pkg::MAX_WIDTH-1:0] result_o,
  output divsqrt_pkg::status_t              status_o
);
  import divsqrt_pkg::*;

  typedef enum logic [1:0] {CORE_IDLE, CORE_LOAD, CORE_RUN, CORE_FIN} core_state_e;

  core_state_e          state_q;
  logic [6:0]           cnt_q;      // Iterations left minus one
  logic                 done_q;
  logic [MAX_WIDTH:0]   acc_q;      // Partial remainder, one spare bit
  logic [MAX_WIDTH-1:0] sh_q;       // Left-aligned dividend or radicand
  logic [MAX_WIDTH-1:0] res_q;      // Quotient or root, LSB first in
  logic [MAX_WIDTH-1:0] result_q;
  status_t              status_q;

  logic                 is_div;
  logic                 fmt_bad;
  logic                 div_zero;
  logic [7:0]           width;
  logic [6:0]           n_iter;
  logic [MAX_WIDTH-1:0] fmt_mask;   // Ones inside the format width
  logic [MAX_WIDTH:0]   shifted, trial, diff;
  logic                 ge;
  logic [MAX_WIDTH-1:0] fin_result;
  status_t              fin_status;

  // ------------------------------------------------------------
  // Format decode
  // ------------------------------------------------------------
  assign is_div   = (op_i == OP_DIV);
  assign fmt_bad  = (fmt_onehot_i == '0);
  assign width    = 8'(fmt_width(fmt_onehot_i));
  assign fmt_mask = {MAX_WIDTH{1'b1}} >> (MAX_WIDTH - width);
  assign div_zero = is_div & ((src1_i & fmt_mask) == '0);

  always_comb begin
    if (fmt_bad)     n_iter = 7'd1;        // Ends right away
    else if (is_div) n_iter = width[6:0];  // One bit per format bit
    else             n_iter = width[7:1];  // Root has half the bits
  end

  // ------------------------------------------------------------
  // One iteration, shared trial subtract
  // ------------------------------------------------------------
  always_comb begin
    if (is_div) begin
      shifted = {acc_q[MAX_WIDTH-1:0], sh_q[MAX_WIDTH-1]};
      trial   = {1'b0, src1_i & fmt_mask};      // Divisor, box bits stripped
    end else begin
      shifted = {acc_q[MAX_WIDTH-2:0], sh_q[MAX_WIDTH-1 -: 2]}; // Bring down a bit pair
      trial   = {res_q[MAX_WIDTH-2:0], 2'b01};  // 4*root + 1
    end
    ge   = (shifted >= trial);
    diff = shifted - trial;
  end

  // Result rules
  always_comb begin
    fin_status.nv = fmt_bad;
    fin_status.dz = div_zero & ~fmt_bad;
    if (fmt_bad || div_zero) fin_result = '1;
    else                     fin_result = (res_q & fmt_mask) | ~fmt_mask; // Ones-box
  end

  // ------------------------------------------------------------
  // Sequencing
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= CORE_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else if (flush_i) begin
      state_q <= CORE_IDLE;             // Abort, nothing is reported
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;                   // Single-cycle strobe
      unique case (state_q)
        CORE_IDLE: if (start_i) state_q <= CORE_LOAD; // Operands land in the box
        CORE_LOAD: begin
          cnt_q   <= n_iter - 7'd1;
          state_q <= CORE_RUN;
        end
        CORE_RUN: begin
          cnt_q <= cnt_q - 7'd1;
          if (cnt_q == '0) state_q <= CORE_FIN;
        end
        CORE_FIN: begin
          done_q  <= 1'b1;
          state_q <= CORE_IDLE;
        end
        default: state_q <= CORE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == CORE_LOAD) begin
      acc_q <= '0;
      res_q <= '0;
      sh_q  <= src0_i << (MAX_WIDTH - width); // Align MSB of the format
    end else if (state_q == CORE_RUN) begin
      acc_q <= ge ? diff : shifted;            // Restore on a failed trial
      res_q <= {res_q[MAX_WIDTH-2:0], ge};
      sh_q  <= is_div ? (sh_q << 1) : (sh_q << 2);
    end
    if (state_q == CORE_FIN) begin
      result_q <= fin_result;
      status_q <= fin_status;
    end
  end

  assign done_o   = done_q;
  assign busy_o   = (state_q != CORE_IDLE);
  assign result_o = result_q;
  assign status_o = status_q;

endmodule

// File: rtl/divsqrt_ctrl.sv
// ------------------------------------------------------------
// Issue FSM, tag register, hold register and output select
// ------------------------------------------------------------
`timescale 1ns/1ps

module divsqrt_ctrl #(
  parameter int unsigned TagWidth = divsqrt_pkg::TAG_WIDTH
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              flush_i,
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  input  logic [TagWidth-1:0]               tag_i,
  output logic                              start_o,
  input  logic                              core_done_i,
  input  logic [divsqrt_pkg::MAX_WIDTH-1:0] core_result_i,
  input  divsqrt_pkg::status_t              core_status_i,
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic [divsqrt_pkg::MAX_WIDTH-1:0] result_o,
  output divsqrt_pkg::status_t              status_o,
  output logic [TagWidth-1:0]               tag_o,
  output logic                              busy_o
);
  import divsqrt_pkg::*;

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} fsm_state_e;

  fsm_state_e           state_q, state_d;
  logic                 in_ready;
  logic                 out_valid;
  logic                 unit_busy;
  logic                 hold_en;
  logic [TagWidth-1:0]  tag_q;
  logic [MAX_WIDTH-1:0] held_result_q;
  status_t              held_status_q;

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------
  always_comb begin
    in_ready  = 1'b0;
    out_valid = 1'b0;
    unit_busy = 1'b0;
    state_d   = state_q;
    unique case (state_q)
      IDLE: begin
        in_ready = 1'b1;
        if (in_valid_i) state_d = BUSY;
      end
      BUSY: begin
        unit_busy = 1'b1;
        if (core_done_i) begin
          out_valid = 1'b1;
          if (out_ready_i) begin
            in_ready = 1'b1;                      // Next op may start now
            state_d  = in_valid_i ? BUSY : IDLE;
          end else begin
            state_d = HOLD;                       // Park result downstream stalls
          end
        end
      end
      HOLD: begin
        unit_busy = 1'b1;
        out_valid = 1'b1;
        if (out_ready_i) begin
          in_ready = 1'b1;
          state_d  = in_valid_i ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    // Flush wins over everything
    if (flush_i) begin
      in_ready  = 1'b0;
      out_valid = 1'b0;
      unit_busy = 1'b0;
      state_d   = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) state_q <= IDLE;
    else          state_q <= state_d;
  end

  assign start_o = in_valid_i & in_ready; // Strobe, in_ready already low on flush
  assign hold_en = core_done_i & ~out_ready_i;

  // Tag follows the op into the core, result parked on a stall
  always_ff @(posedge clk_i) begin
    if (start_o) tag_q <= tag_i;
    if (hold_en) begin
      held_result_q <= core_result_i;
      held_status_q <= core_status_i;
    end
  end

  // ------------------------------------------------------------
  // Output select, held data first
  // ------------------------------------------------------------
  assign result_o    = (state_q == HOLD) ? held_result_q : core_result_i;
  assign status_o    = (state_q == HOLD) ? held_status_q : core_status_i;
  assign tag_o       = tag_q;
  assign out_valid_o = out_valid;
  assign in_ready_o  = in_ready;
  assign busy_o      = unit_busy;

endmodule

// File: rtl/divsqrt_top.sv
// ------------------------------------------------------------
// Integer divide/sqrt unit: input pipe, control, core, output pipe
// ------------------------------------------------------------
`timescale 1ns/1ps

module divsqrt_top #(
  parameter int unsigned NumInpRegs = 0,
  parameter int unsigned NumOutRegs = 0,
  parameter int unsigned TagWidth   = divsqrt_pkg::TAG_WIDTH
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   flush_i,
  input  logic                                   in_valid_i,
  output logic                                   in_ready_o,
  input  logic [1:0][divsqrt_pkg::MAX_WIDTH-1:0] operands_i,
  input  divsqrt_pkg::op_e                       op_i,
  input  divsqrt_pkg::fmt_e                      fmt_i,
  input  logic [TagWidth-1:0]                    tag_i,
  output logic                                   out_valid_o,
  input  logic                                   out_ready_i,
  output logic [divsqrt_pkg::MAX_WIDTH-1:0]      result_o,
  output divsqrt_pkg::status_t                   status_o,
  output logic [TagWidth-1:0]                    tag_o,
  output logic                                   busy_o
);
  import divsqrt_pkg::*;

  typedef struct packed {
    logic [1:0][MAX_WIDTH-1:0] operands;
    op_e                       op;
    fmt_e                      fmt;
    logic [TagWidth-1:0]       tag;
  } inp_payload_t;

  typedef struct packed {
    logic [MAX_WIDTH-1:0] result;
    status_t              status;
    logic [TagWidth-1:0]  tag;
  } out_payload_t;

  inp_payload_t         inp_data, issue_data;
  out_payload_t         res_data, out_data;
  logic                 issue_valid, issue_ready;
  logic                 res_valid, res_ready;
  logic                 inp_busy, out_busy, ctrl_busy;
  logic                 start;
  op_e                  box_op;
  fmt_onehot_t          box_fmt;
  logic [MAX_WIDTH-1:0] src0, src1;
  logic                 core_done;
  logic [MAX_WIDTH-1:0] core_result;
  status_t              core_status;

  assign inp_data.operands = operands_i;
  assign inp_data.op       = op_i;
  assign inp_data.fmt      = fmt_i;
  assign inp_data.tag      = tag_i;

  divsqrt_pipe_stage #(.PayloadType(inp_payload_t), .NumRegs(NumInpRegs)) u_inp_pipe (
    .clk_i, .rst_n_i, .flush_i,
    .in_valid_i, .in_ready_o, .in_data_i(inp_data),
    .out_valid_o(issue_valid), .out_ready_i(issue_ready), .out_data_o(issue_data),
    .valid_any_o(inp_busy)
  );

  divsqrt_ctrl #(.TagWidth(TagWidth)) u_ctrl (
    .clk_i, .rst_n_i, .flush_i,
    .in_valid_i(issue_valid), .in_ready_o(issue_ready), .tag_i(issue_data.tag),
    .start_o(start),
    .core_done_i(core_done), .core_result_i(core_result), .core_status_i(core_status),
    .out_valid_o(res_valid), .out_ready_i(res_ready),
    .result_o(res_data.result), .status_o(res_data.status), .tag_o(res_data.tag),
    .busy_o(ctrl_busy)
  );

  divsqrt_operand_box u_operand_box (
    .clk_i, .rst_n_i, .start_i(start),
    .op_i(issue_data.op), .fmt_i(issue_data.fmt),
    .operand0_i(issue_data.operands[0]), .operand1_i(issue_data.operands[1]),
    .op_o(box_op), .fmt_onehot_o(box_fmt), .src0_o(src0), .src1_o(src1)
  );

  divsqrt_iter_core u_core (
    .clk_i, .rst_n_i, .flush_i, .start_i(start),
    .op_i(box_op), .fmt_onehot_i(box_fmt), .src0_i(src0), .src1_i(src1),
    .done_o(core_done), .busy_o(), .result_o(core_result), .status_o(core_status)
  );

  divsqrt_pipe_stage #(.PayloadType(out_payload_t), .NumRegs(NumOutRegs)) u_out_pipe (
    .clk_i, .rst_n_i, .flush_i,
    .in_valid_i(res_valid), .in_ready_o(res_ready), .in_data_i(res_data),
    .out_valid_o, .out_ready_i, .out_data_o(out_data),
    .valid_any_o(out_busy)
  );

  assign result_o = out_data.result;
  assign status_o = out_data.status;
  assign tag_o    = out_data.tag;
  assign busy_o   = inp_busy | ctrl_busy | out_busy; // Either pipe or the issued op

endmodule

// File: testbench/divsqrt_checker.sv
// ------------------------------------------------------------
// Handshake and reset assertions, bound into divsqrt_top
// ------------------------------------------------------------
`timescale 1ns/1ps

module divsqrt_checker #(
  parameter int unsigned TagWidth = divsqrt_pkg::TAG_WIDTH
) (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic                              flush_i,
  input logic                              in_ready_i,
  input logic                              out_valid_i,
  input logic                              out_ready_i,
  input logic [divsqrt_pkg::MAX_WIDTH-1:0] result_i,
  input divsqrt_pkg::status_t              status_i,
  input logic [TagWidth-1:0]               tag_i,
  input logic                              busy_i
);

  int unsigned assert_errs = 0;  // Failed assertions so far

  // Stalled output keeps valid and all payload fields
  out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i && !flush_i |=>
      out_valid_i && $stable(result_i) && $stable(status_i) && $stable(tag_i))
    else begin
      $error("Output changed while stalled");
      assert_errs++;
    end

  // Flush empties the output side at once
  flush_drops: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_i)
    else begin
      $error("Output valid in the cycle after flush");
      assert_errs++;
    end

  // Leaving reset the unit is empty and ready
  reset_state: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> in_ready_i && !out_valid_i && !busy_i)
    else begin
      $error("Wrong handshake state after reset");
      assert_errs++;
    end

endmodule

bind divsqrt_top divsqrt_checker #(.TagWidth(TagWidth)) u_checker (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .flush_i    (flush_i),
  .in_ready_i (in_ready_o),
  .out_valid_i(out_valid_o),
  .out_ready_i(out_ready_i),
  .result_i   (result_o),
  .status_i   (status_o),
  .tag_i      (tag_o),
  .busy_i     (busy_o)
);

// File: testbench/divsqrt_tb.sv
// ------------------------------------------------------------
// Testbench for divsqrt_top: drivers, reference model, checks
// ------------------------------------------------------------
`timescale 1ns/1ps

module divsqrt_tb;
  import divsqrt_pkg::*;

  localparam int unsigned TagW    = TAG_WIDTH;
  localparam int unsigned Timeout = 300;  // Cycles, longest op plus pipes

  typedef struct packed {
    logic [MAX_WIDTH-1:0] result;
    status_t              status;
    logic [TagW-1:0]      tag;
  } expect_t;

  logic                      clk, rst_n, flush;
  logic                      in_valid, in_ready;
  logic [1:0][MAX_WIDTH-1:0] operands;
  op_e                       op;
  fmt_e                      fmt;
  logic [TagW-1:0]           tag_in, tag_out;
  logic                      out_valid, out_ready;
  logic [MAX_WIDTH-1:0]      result;
  status_t                   status;
  logic                      busy;

  expect_t         expected_q [$];  // Issued ops, oldest first
  int unsigned     mismatches, timeouts, other_errs;
  int              seed;
  logic [TagW-1:0] tag_cnt;

  divsqrt_top #(.NumInpRegs(1), .NumOutRegs(1), .TagWidth(TagW)) u_dut (
    .clk_i(clk), .rst_n_i(rst_n), .flush_i(flush),
    .in_valid_i(in_valid), .in_ready_o(in_ready), .operands_i(operands),
    .op_i(op), .fmt_i(fmt), .tag_i(tag_in),
    .out_valid_o(out_valid), .out_ready_i(out_ready), .result_o(result),
    .status_o(status), .tag_o(tag_out), .busy_o(busy)
  );

  always #4 clk = ~clk;  // 8 ns period

  // ------------------------------------------------------------
  // Reference model and stimulus helpers
  // ------------------------------------------------------------
  function automatic expect_t predict(op_e op_v, fmt_e fmt_v, logic [MAX_WIDTH-1:0] a,
                                      logic [MAX_WIDTH-1:0] b, logic [TagW-1:0] tag_v);
    expect_t              e;
    int unsigned          w;
    logic [MAX_WIDTH-1:0] mask, cand, root;
    e.tag    = tag_v;
    e.status = '0;
    case (fmt_v)
      FMT64:   w = 64;
      FMT32:   w = 32;
      FMT16:   w = 16;
      default: w = 0;   // Unsupported
    endcase
    if (w == 0) begin
      e.result    = '1;
      e.status.nv = 1'b1;
      return e;
    end
    mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    a    = a & mask;     // Only the low format bits count
    b    = b & mask;
    if (op_v == OP_DIV) begin
      if (b == '0) begin
        e.result    = '1;
        e.status.dz = 1'b1;
      end else begin
        e.result = (a / b) | ~mask;
      end
    end else begin
      root = '0;
      // Largest root whose square still fits, one bit at a time from the top
      for (int i = int'(w / 2) - 1; i >= 0; i--) begin
        cand = root | (64'd1 << i);
        if (cand * cand <= a) root = cand;
      end
      e.result = root | ~mask;
    end
    return e;
  endfunction

  function automatic logic [MAX_WIDTH-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_result(input logic [MAX_WIDTH-1:0] got, input logic [MAX_WIDTH-1:0] exp_v);
    if (got !== exp_v) begin
      $display("Mismatch result_o: got %h expected %h", got, exp_v);
      mismatches++;
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp_v);
    if (got !== exp_v) begin
      $display("Mismatch status_o: got %h expected %h", got, exp_v);
      mismatches++;
    end
  endtask

  task automatic check_tag(input logic [TagW-1:0] got, input logic [TagW-1:0] exp_v);
    if (got !== exp_v) begin
      $display("Mismatch tag_o: got %h expected %h", got, exp_v);
      mismatches++;
    end
  endtask

  // ------------------------------------------------------------
  // Driver tasks, entered and left 1 ns after a rising edge
  // ------------------------------------------------------------
  task automatic send_op(input op_e op_v, input fmt_e fmt_v,
                         input logic [MAX_WIDTH-1:0] a, input logic [MAX_WIDTH-1:0] b);
    int unsigned cycles;
    cycles      = 0;
    in_valid    = 1'b1;
    operands[0] = a;
    operands[1] = b;
    op          = op_v;
    fmt         = fmt_v;
    tag_in      = tag_cnt;
    @(negedge clk);
    while (!in_ready && cycles < Timeout) begin  // Ready settles before the falling edge
      cycles++;
      @(negedge clk);
    end
    if (!in_ready) begin
      $display("Timeout: operation with tag %h was never accepted", tag_cnt);
      timeouts++;
    end else begin
      expected_q.push_back(predict(op_v, fmt_v, a, b, tag_cnt));
    end
    @(posedge clk);   // Handshake edge
    #1;
    in_valid = 1'b0;
    tag_cnt++;
  endtask

  task automatic expect_result();
    int unsigned cycles;
    expect_t     exp_v;
    cycles    = 0;
    out_ready = 1'b1;
    @(negedge clk);
    while (!out_valid && cycles < Timeout) begin
      cycles++;
      @(negedge clk);
    end
    if (!out_valid) begin
      $display("Timeout: no result within %0d cycles", Timeout);
      timeouts++;
      if (expected_q.size() > 0) void'(expected_q.pop_front());  // Stay in step
    end else if (expected_q.size() == 0) begin
      $display("Error: result delivered with no operation outstanding");
      other_errs++;
    end else begin
      exp_v = expected_q.pop_front();
      check_result(result, exp_v.result);
      check_status(status, exp_v.status);
      check_tag(tag_out, exp_v.tag);
    end
    @(posedge clk);
    #1;
    out_ready = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_divide();
    fmt_e                 fmts [3];
    logic [MAX_WIDTH-1:0] a, b;
    fmts = '{FMT64, FMT32, FMT16};
    foreach (fmts[f]) begin
      for (int n = 0; n < 4; n++) begin
        a = rand64();
        b = rand64() >> ($unsigned($random(seed)) % 60);  // Spread of quotient sizes
        send_op(OP_DIV, fmts[f], a, b);
        expect_result();
      end
    end
  endtask

  task automatic test_sqrt();
    fmt_e                 fmts [3];
    logic [MAX_WIDTH-1:0] vals [5];
    fmts = '{FMT64, FMT32, FMT16};
    vals = '{64'd0, 64'd144, {MAX_WIDTH{1'b1}}, rand64(), rand64()};
    foreach (fmts[f]) begin
      foreach (vals[v]) begin
        send_op(OP_SQRT, fmts[f], vals[v], rand64());  // Operand 1 is ignored
        expect_result();
      end
    end
  endtask

  task automatic test_special();
    send_op(OP_DIV, FMT64, 64'd123, 64'd0);
    expect_result();
    send_op(OP_DIV, FMT32, rand64(), 64'hffff_ffff_0000_0000);  // Zero in the low word
    expect_result();
    send_op(OP_DIV, FMT16, rand64(), 64'h0000_0000_5555_0000);
    expect_result();
    send_op(OP_DIV, FMT_UNSUP, rand64(), rand64());
    expect_result();
    send_op(OP_SQRT, FMT_UNSUP, rand64(), rand64());
    expect_result();
  endtask

  task automatic test_backpressure();
    out_ready = 1'b0;
    send_op(OP_DIV, FMT64, rand64(), rand64() >> 20);
    send_op(OP_SQRT, FMT64, rand64(), '0);
    send_op(OP_DIV, FMT32, rand64(), rand64() >> 40);
    repeat (150) @(posedge clk);  // Results pile up behind the stall
    #1;
    if (!out_valid) begin
      $display("Error: output valid dropped while the output was stalled");
      other_errs++;
    end
    repeat (3) expect_result();
  endtask

  task automatic test_flush();
    send_op(OP_DIV, FMT64, rand64(), rand64() >> 8);
    repeat (10) @(posedge clk);   // Op is deep inside the core
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush     = 1'b0;
    out_ready = 1'b1;
    if (expected_q.size() > 0) void'(expected_q.pop_back());  // That op is gone
    @(negedge clk);
    if (busy) begin
      $display("Error: busy_o still high after flush");
      other_errs++;
    end
    for (int n = 0; n < 100; n++) begin
      if (out_valid) begin
        $display("Error: result delivered after flush");
        other_errs++;
        break;
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    out_ready = 1'b0;
    send_op(OP_SQRT, FMT32, rand64(), '0);
    expect_result();
  endtask

  task automatic test_back_to_back();
    fork
      begin
        send_op(OP_DIV, FMT16, rand64(), rand64() >> 56);
        send_op(OP_SQRT, FMT32, rand64(), '0);
        send_op(OP_DIV, FMT64, rand64(), rand64() >> 33);
      end
      begin
        repeat (3) expect_result();  // Collect in parallel, order must hold
      end
    join
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    flush      = 1'b0;
    in_valid   = 1'b0;
    operands   = '0;
    op         = OP_DIV;
    fmt        = FMT64;
    tag_in     = '0;
    out_ready  = 1'b0;
    mismatches = 0;
    timeouts   = 0;
    other_errs = 0;
    seed       = 32'h6f28be25;
    tag_cnt    = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (!in_ready || out_valid || busy) begin
      $display("Error: unit not idle and ready after reset");
      other_errs++;
    end
    @(posedge clk);
    #1;
    test_divide();
    test_sqrt();
    test_special();
    test_backpressure();
    test_flush();
    test_back_to_back();
    repeat (5) @(posedge clk);
    if (expected_q.size() != 0) begin
      $display("Error: %0d expected results never arrived", expected_q.size());
      other_errs++;
    end
    $display("Summary: %0d mismatches, %0d timeouts, %0d other errors, %0d assertion failures",
             mismatches, timeouts, other_errs, u_dut.u_checker.assert_errs);
    if (mismatches + timeouts + other_errs + u_dut.u_checker.assert_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: src.f
rtl/divsqrt_pkg.sv
rtl/divsqrt_pipe_stage.sv
rtl/divsqrt_operand_box.sv
rtl/divsqrt_iter_core.sv
rtl/divsqrt_ctrl.sv
rtl/divsqrt_top.sv
testbench/divsqrt_checker.sv
testbench/divsqrt_tb.sv
